//--- verilog/eth_tx_pkg.sv
package eth_tx_pkg;

  localparam int PREAMBLE_LEN = 8;  // 7 x 0x55 plus SFD
  localparam int HDR_LEN      = 22; // Preamble plus dst, src, type
  localparam int MIN_PAYLOAD  = 46;

  localparam logic [7:0]  PREAMBLE_BYTE = 8'h55;
  localparam logic [7:0]  SFD_BYTE      = 8'hD5;
  localparam logic [31:0] CRC_POLY      = 32'hEDB88320; // Reflected form

  typedef logic [47:0] mac_addr_t;
  typedef logic [10:0] length_t;

  typedef struct packed {
    mac_addr_t   dst_mac;
    mac_addr_t   src_mac;
    logic [15:0] ethertype;
    length_t     length;
  } frame_meta_t;

  typedef struct packed {
    logic       val;
    logic [7:0] dat;
  } phy_stream_t;

  typedef struct packed {
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
  } apb_rsp_t;

  typedef enum logic [7:0] {
    CTRL     = 8'h00,
    STATUS   = 8'h04,
    SRC_LO   = 8'h08,
    SRC_HI   = 8'h0C,
    DST_LO   = 8'h10,
    DST_HI   = 8'h14,
    TYPE_LEN = 8'h18, // [15:0] ethertype, [26:16] length
    PAYLOAD  = 8'h1C
  } reg_addr_e;

  typedef enum logic [1:0] {
    IDLE,
    HDR,
    PLD,
    FCS
  } tx_state_e;

endpackage

//--- verilog/eth_crc32.sv
`timescale 1ns/1ns

module eth_crc32 (
  input  logic        clk,
  input  logic        fsm_rst,
  input  logic        en,
  input  logic [7:0]  dat,
  output logic [31:0] crc
);

  // Fold one byte, LSB first
  function automatic logic [31:0] crc_byte(
    input logic [31:0] c,
    input logic [7:0]  d
  );
    logic [31:0] r;
    r = c ^ {24'd0, d};
    for (int i = 0; i < 8; i++) begin
      if (r[0]) begin
        r = (r >> 1) ^ eth_tx_pkg::CRC_POLY;
      end else begin
        r = r >> 1;
      end
    end
    return r;
  endfunction

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      crc <= '1; // Standard all-ones seed
    end else if (en) begin
      crc <= crc_byte(crc, dat);
    end
  end

endmodule

//--- verilog/mac_tx.sv
`timescale 1ns/1ns

module mac_tx (
  input  logic                    clk,
  input  logic                    fsm_rst,
  input  eth_tx_pkg::frame_meta_t meta,
  input  logic                    tx_rdy,
  output logic                    tx_acc,
  output logic                    pld_req,
  input  logic [7:0]              pld_dat,
  output logic                    tx_done,
  output eth_tx_pkg::phy_stream_t phy
);

  localparam int HDR_CW = $clog2(eth_tx_pkg::HDR_LEN);
  localparam eth_tx_pkg::length_t MIN_LEN = eth_tx_pkg::length_t'(eth_tx_pkg::MIN_PAYLOAD);

  eth_tx_pkg::tx_state_e state;

  logic                                restart;
  logic [eth_tx_pkg::HDR_LEN-1:0][7:0] hdr_sr;
  logic [HDR_CW-1:0]                   hdr_cnt;
  eth_tx_pkg::length_t                 cur_len;
  eth_tx_pkg::length_t                 pld_total;
  eth_tx_pkg::length_t                 pld_cnt;
  logic [2:0]                          fcs_cnt;
  logic [31:0]                         fcs_sr;
  logic [31:0]                         fcs_word;
  logic [31:0]                         crc;
  logic                                crc_en;
  logic                                crc_clr;
  logic [7:0]                          nxt_byte;
  logic                                val_q;
  logic [7:0]                          dat_q;

  assign crc_clr = fsm_rst || (state == eth_tx_pkg::IDLE);

  eth_crc32 u_crc (
    .clk     (clk),
    .fsm_rst (crc_clr),
    .en      (crc_en),
    .dat     (nxt_byte),
    .crc     (crc)
  );

  assign fcs_word = (fcs_cnt == 3'd0) ? ~crc : fcs_sr; // CRC final on first FCS cycle

  // Byte that goes to the PHY register on this edge
  always_comb begin
    nxt_byte = 8'h00;
    crc_en   = 1'b0;
    case (state)
      eth_tx_pkg::HDR: begin
        nxt_byte = hdr_sr[eth_tx_pkg::HDR_LEN-1];
        crc_en   = (hdr_cnt >= HDR_CW'(eth_tx_pkg::PREAMBLE_LEN)); // From dst address on
      end
      eth_tx_pkg::PLD: begin
        nxt_byte = pld_req ? pld_dat : 8'h00; // Zero pad past length
        crc_en   = 1'b1;
      end
      eth_tx_pkg::FCS: nxt_byte = fcs_word[7:0];
      default: ;
    endcase
  end

  assign restart = fsm_rst || tx_done;

  always_ff @(posedge clk) begin
    if (restart) begin
      state   <= eth_tx_pkg::IDLE;
      tx_acc  <= 1'b0;
      pld_req <= 1'b0;
      tx_done <= 1'b0;
      val_q   <= 1'b0;
      hdr_cnt <= '0;
      pld_cnt <= '0;
      fcs_cnt <= '0;
    end else begin
      tx_acc <= 1'b0;
      case (state)
        eth_tx_pkg::IDLE: begin
          if (tx_rdy) begin
            tx_acc    <= 1'b1;
            state     <= eth_tx_pkg::HDR;
            cur_len   <= meta.length;
            pld_total <= (meta.length < MIN_LEN) ? MIN_LEN : meta.length;
            hdr_sr    <= {{(eth_tx_pkg::PREAMBLE_LEN-1){eth_tx_pkg::PREAMBLE_BYTE}},
                          eth_tx_pkg::SFD_BYTE, meta.dst_mac, meta.src_mac, meta.ethertype};
          end
        end
        eth_tx_pkg::HDR: begin
          val_q   <= 1'b1;
          dat_q   <= nxt_byte;
          hdr_sr  <= {hdr_sr[eth_tx_pkg::HDR_LEN-2:0], 8'h00};
          hdr_cnt <= hdr_cnt + 1'b1;
          if (hdr_cnt == HDR_CW'(eth_tx_pkg::HDR_LEN - 1)) begin
            state   <= eth_tx_pkg::PLD;
            pld_req <= (cur_len != '0);
          end
        end
        eth_tx_pkg::PLD: begin
          dat_q   <= nxt_byte;
          pld_cnt <= pld_cnt + 1'b1;
          if (pld_cnt == cur_len - 11'd1) pld_req <= 1'b0;
          if (pld_cnt == pld_total - 11'd1) state <= eth_tx_pkg::FCS;
        end
        eth_tx_pkg::FCS: begin
          if (fcs_cnt == 3'd4) begin
            val_q   <= 1'b0;
            tx_done <= 1'b1; // Also restarts the FSM next cycle
          end else begin
            dat_q   <= nxt_byte;
            fcs_sr  <= fcs_word >> 8;
            fcs_cnt <= fcs_cnt + 1'b1;
          end
        end
        default: ;
      endcase
    end
  end

  assign phy = '{val: val_q, dat: dat_q};

  a_val_no_gap: assert property (@(posedge clk) disable iff (fsm_rst)
    $fell(val_q) |-> (hdr_cnt == HDR_CW'(eth_tx_pkg::HDR_LEN) && pld_cnt == pld_total &&
                      fcs_cnt == 3'd4));

  a_req_in_pld: assert property (@(posedge clk) disable iff (fsm_rst)
    pld_req |-> (state == eth_tx_pkg::PLD));

endmodule

//--- verilog/eth_tx_regs.sv
`timescale 1ns/1ns

module eth_tx_regs #(
  parameter int FIFO_DEPTH = 64
) (
  input  logic                    clk,
  input  logic                    fsm_rst,
  input  eth_tx_pkg::apb_req_t    apb_req,
  output eth_tx_pkg::apb_rsp_t    apb_rsp,
  output eth_tx_pkg::frame_meta_t meta,
  output logic                    tx_rdy,
  input  logic                    tx_acc,
  input  logic                    pld_req,
  output logic [7:0]              pld_dat,
  input  logic                    tx_done,
  output logic                    irq_done
);

  localparam int AW = $clog2(FIFO_DEPTH);
  localparam logic [AW:0] FULL_CNT = FIFO_DEPTH[AW:0];

  logic [7:0]            fifo_mem [FIFO_DEPTH];
  logic [AW-1:0]         wr_ptr;
  logic [AW-1:0]         rd_ptr;
  logic [AW:0]           fifo_cnt;
  logic                  busy;
  logic [15:0]           frames_sent;
  logic                  access;
  logic                  err;
  logic                  wr_ok;
  logic                  push;
  logic                  start_ok;
  logic [31:0]           rdata;
  eth_tx_pkg::reg_addr_e addr;

  assign access = apb_req.psel && apb_req.penable;
  assign addr   = eth_tx_pkg::reg_addr_e'(apb_req.paddr);

  always_comb begin
    err   = 1'b0;
    rdata = '0;
    case (addr)
      eth_tx_pkg::CTRL:     err   = apb_req.pwrite && apb_req.pwdata[0] && busy;
      eth_tx_pkg::STATUS:   rdata = {frames_sent, 8'(fifo_cnt), 7'd0, busy};
      eth_tx_pkg::SRC_LO:   rdata = meta.src_mac[31:0];
      eth_tx_pkg::SRC_HI:   rdata = {16'd0, meta.src_mac[47:32]};
      eth_tx_pkg::DST_LO:   rdata = meta.dst_mac[31:0];
      eth_tx_pkg::DST_HI:   rdata = {16'd0, meta.dst_mac[47:32]};
      eth_tx_pkg::TYPE_LEN: rdata = {5'd0, meta.length, meta.ethertype};
      eth_tx_pkg::PAYLOAD:  err   = apb_req.pwrite && (fifo_cnt == FULL_CNT);
      default:              err   = 1'b1; // Unmapped offset
    endcase
  end

  assign wr_ok    = access && apb_req.pwrite && !err;
  assign push     = wr_ok && (addr == eth_tx_pkg::PAYLOAD);
  assign start_ok = wr_ok && (addr == eth_tx_pkg::CTRL) && apb_req.pwdata[0];

  assign apb_rsp = '{prdata:  (access && !apb_req.pwrite) ? rdata : 32'd0,
                     pready:  1'b1,
                     pslverr: access && err};

  always_ff @(posedge clk) begin
    if (wr_ok) begin
      case (addr)
        eth_tx_pkg::SRC_LO: meta.src_mac[31:0]  <= apb_req.pwdata;
        eth_tx_pkg::SRC_HI: meta.src_mac[47:32] <= apb_req.pwdata[15:0];
        eth_tx_pkg::DST_LO: meta.dst_mac[31:0]  <= apb_req.pwdata;
        eth_tx_pkg::DST_HI: meta.dst_mac[47:32] <= apb_req.pwdata[15:0];
        eth_tx_pkg::TYPE_LEN: begin
          meta.ethertype <= apb_req.pwdata[15:0];
          meta.length    <= apb_req.pwdata[26:16];
        end
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push) fifo_mem[wr_ptr] <= apb_req.pwdata[7:0];
  end

  assign pld_dat = fifo_mem[rd_ptr]; // FWFT head

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      busy        <= 1'b0;
      tx_rdy      <= 1'b0;
      frames_sent <= '0;
      wr_ptr      <= '0;
      rd_ptr      <= '0;
      fifo_cnt    <= '0;
    end else begin
      if (start_ok) begin
        busy   <= 1'b1;
        tx_rdy <= 1'b1;
      end else if (tx_acc) begin
        tx_rdy <= 1'b0;
      end
      if (tx_done) begin
        busy        <= 1'b0;
        frames_sent <= frames_sent + 16'd1;
      end
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pld_req) rd_ptr <= rd_ptr + 1'b1;
      case ({push, pld_req})
        2'b10:   fifo_cnt <= fifo_cnt + 1'b1;
        2'b01:   fifo_cnt <= fifo_cnt - 1'b1;
        default: ;
      endcase
    end
  end

  assign irq_done = tx_done;

  a_no_underflow: assert property (@(posedge clk) disable iff (fsm_rst)
    pld_req |-> (fifo_cnt != '0));

endmodule

//--- verilog/eth_tx_top.sv
`timescale 1ns/1ns

module eth_tx_top #(
  parameter int FIFO_DEPTH = 64
) (
  input  logic                    clk,
  input  logic                    fsm_rst,
  input  eth_tx_pkg::apb_req_t    apb_req,
  output eth_tx_pkg::apb_rsp_t    apb_rsp,
  output eth_tx_pkg::phy_stream_t phy,
  output logic                    irq_done
);

  eth_tx_pkg::frame_meta_t meta;
  logic                    tx_rdy;
  logic                    tx_acc;
  logic                    pld_req;
  logic [7:0]              pld_dat;
  logic                    tx_done;

  eth_tx_regs #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_regs (
    .clk      (clk),
    .fsm_rst  (fsm_rst),
    .apb_req  (apb_req),
    .apb_rsp  (apb_rsp),
    .meta     (meta),
    .tx_rdy   (tx_rdy),
    .tx_acc   (tx_acc),
    .pld_req  (pld_req),
    .pld_dat  (pld_dat),
    .tx_done  (tx_done),
    .irq_done (irq_done)
  );

  mac_tx u_mac_tx (
    .clk     (clk),
    .fsm_rst (fsm_rst),
    .meta    (meta),
    .tx_rdy  (tx_rdy),
    .tx_acc  (tx_acc),
    .pld_req (pld_req),
    .pld_dat (pld_dat),
    .tx_done (tx_done),
    .phy     (phy)
  );

endmodule

//--- test/eth_tx_checker.sv
`timescale 1ns/1ns

module eth_tx_checker #(
  parameter int FIFO_DEPTH = 64
) (
  input  logic                       clk,
  input  logic                       fsm_rst,
  input  int                         cyc,
  input  eth_tx_pkg::phy_stream_t    phy,
  input  logic                       irq_done,
  input  eth_tx_pkg::apb_rsp_t       apb_rsp,
  input  logic                       chk_rsp,
  input  logic                       chk_rd,
  input  logic                       exp_err,
  input  logic [31:0]                exp_rd,
  input  logic                       exp_push,
  input  int                         exp_start,
  input  eth_tx_pkg::mac_addr_t      exp_dst,
  input  eth_tx_pkg::mac_addr_t      exp_src,
  input  logic [15:0]                exp_type,
  input  eth_tx_pkg::length_t        exp_len,
  input  logic [31:0]                exp_fcs,
  input  logic [FIFO_DEPTH-1:0][7:0] exp_pld,
  output int                         frame_errs,
  output int                         apb_errs,
  output int                         frames_seen
);

  typedef struct packed {
    eth_tx_pkg::mac_addr_t      dst;
    eth_tx_pkg::mac_addr_t      src;
    logic [15:0]                etype;
    int                         len;
    logic [31:0]                fcs;
    int                         start;
    logic [FIFO_DEPTH-1:0][7:0] pld;
  } frame_t;

  frame_t      exp_q[$];
  frame_t      cur;
  frame_t      nf;
  int          idx;
  int          pld_end;
  int          total;
  logic        in_frame;
  logic        have_exp;
  logic        rst_q;
  logic        fell;
  logic [31:0] crc_acc;
  logic [31:0] crc_rx;
  logic [31:0] fcs;
  logic [7:0]  exp_b;

  initial begin
    frame_errs  = 0;
    apb_errs    = 0;
    frames_seen = 0;
  end

  // Reflected CRC-32 stepped one data bit at a time from the LSB
  function automatic logic [31:0] crc_step(input logic [31:0] c, input logic [7:0] d);
    logic [31:0] r;
    logic        fb;
    r = c;
    for (int b = 0; b < 8; b++) begin
      fb = r[0] ^ d[b];
      r  = {1'b0, r[31:1]} ^ (fb ? 32'hEDB88320 : 32'h0);
    end
    return r;
  endfunction

  // Standard check value over ASCII 123456789
  function automatic logic [31:0] check_value();
    logic [31:0] c;
    c = '1;
    for (int i = 1; i <= 9; i++) c = crc_step(c, 8'h30 + 8'(i));
    return ~c;
  endfunction

  function automatic logic [7:0] hdr_byte(input frame_t f, input int i);
    if (i < 7) return 8'h55;
    if (i == 7) return 8'hD5; // SFD
    if (i < 14) return f.dst[8*(13-i) +: 8]; // MSB byte first
    if (i < 20) return f.src[8*(19-i) +: 8];
    return f.etype[8*(21-i) +: 8];
  endfunction

  task automatic check_apb();
    if (apb_rsp.pready !== 1'b1) begin
      $display("ERROR apb_rsp.pready exp 1 got %h", apb_rsp.pready);
      apb_errs++;
    end
    if (apb_rsp.pslverr !== exp_err) begin
      $display("ERROR apb_rsp.pslverr exp %h got %h", exp_err, apb_rsp.pslverr);
      apb_errs++;
    end
    if (chk_rd && !exp_err && apb_rsp.prdata !== exp_rd) begin
      $display("ERROR apb_rsp.prdata exp %h got %h", exp_rd, apb_rsp.prdata);
      apb_errs++;
    end
  endtask

  task automatic start_frame();
    in_frame = 1'b1;
    idx      = 0;
    crc_acc  = '1;
    crc_rx   = '1;
    have_exp = (exp_q.size() != 0);
    if (!have_exp) begin
      $display("A frame started at cycle %0d with no start pending", cyc);
      frame_errs++;
    end else begin
      cur     = exp_q.pop_front();
      pld_end = eth_tx_pkg::HDR_LEN +
                ((cur.len < eth_tx_pkg::MIN_PAYLOAD) ? eth_tx_pkg::MIN_PAYLOAD : cur.len);
      total   = pld_end + 4;
      if (cyc != cur.start + 3) begin
        $display("First preamble byte at cycle %0d, expected cycle %0d", cyc, cur.start + 3);
        frame_errs++;
      end
    end
  endtask

  task automatic check_byte();
    if (idx < eth_tx_pkg::HDR_LEN) begin
      exp_b = hdr_byte(cur, idx);
    end else if (idx < pld_end) begin
      exp_b = (idx - eth_tx_pkg::HDR_LEN < cur.len) ? cur.pld[idx - eth_tx_pkg::HDR_LEN] : 8'h00;
    end else begin
      if (idx == pld_end) begin
        fcs = ~crc_acc;
        if (cur.fcs != '0 && fcs != cur.fcs) begin
          $display("Computed FCS %h does not match pattern file FCS %h", fcs, cur.fcs);
          frame_errs++;
        end
      end
      exp_b = (idx < total) ? fcs[8*(idx-pld_end) +: 8] : 8'h00; // FCS LSB first
    end
    if (idx >= eth_tx_pkg::PREAMBLE_LEN && idx < pld_end) crc_acc = crc_step(crc_acc, exp_b);
    if (idx >= eth_tx_pkg::PREAMBLE_LEN && idx < total) crc_rx = crc_step(crc_rx, phy.dat);
    if (idx < total && phy.dat !== exp_b) begin
      $display("ERROR phy.dat byte %0d exp %h got %h", idx, exp_b, phy.dat);
      frame_errs++;
    end
    idx++;
  endtask

  task automatic end_frame();
    in_frame = 1'b0;
    if (have_exp) begin
      frames_seen++;
      if (idx != total) begin
        $display("phy.val was high for %0d cycles, expected %0d", idx, total);
        frame_errs++;
      end else if (crc_rx != 32'hDEBB20E3) begin
        $display("CRC residue over the received bytes is %h instead of DEBB20E3", crc_rx);
        frame_errs++;
      end
    end
    have_exp = 1'b0;
  endtask

  always @(negedge clk) begin
    if (fsm_rst) begin
      rst_q    = 1'b1;
      in_frame = 1'b0;
      have_exp = 1'b0;
    end else begin
      if (rst_q) begin
        if (phy.val !== 1'b0 || irq_done !== 1'b0) begin
          $display("phy.val or irq_done is not low right after reset");
          frame_errs++;
        end
        if (check_value() != 32'hCBF43926) begin
          $display("Reference CRC fails its check value");
          frame_errs++;
        end
        rst_q = 1'b0;
      end
      if (exp_push) begin
        nf.dst   = exp_dst;
        nf.src   = exp_src;
        nf.etype = exp_type;
        nf.len   = int'(exp_len);
        nf.fcs   = exp_fcs;
        nf.start = exp_start;
        nf.pld   = exp_pld;
        exp_q.push_back(nf);
      end
      if (chk_rsp) check_apb();
      fell = in_frame && !phy.val;
      if (irq_done !== fell) begin // Pulse in the first idle cycle only
        $display("ERROR irq_done exp %h got %h", fell, irq_done);
        frame_errs++;
      end
      if (phy.val && !in_frame) start_frame();
      if (phy.val && have_exp) check_byte();
      if (fell) end_frame();
    end
  end

endmodule

//--- test/tb_eth_tx.sv
`timescale 1ns/1ns

module tb_eth_tx;

  localparam int FIFO_DEPTH = 64;
  localparam int MAX_FRAMES = 8;

  logic                       clk;
  logic                       fsm_rst;
  eth_tx_pkg::apb_req_t       apb_req;
  eth_tx_pkg::apb_rsp_t       apb_rsp;
  eth_tx_pkg::phy_stream_t    phy;
  logic                       irq_done;

  int                         cyc = 0;
  int                         acc_cyc;
  logic                       chk_rsp;
  logic                       chk_rd;
  logic                       exp_err;
  logic [31:0]                exp_rd;
  logic                       exp_push;
  int                         exp_start;
  eth_tx_pkg::mac_addr_t      exp_dst;
  eth_tx_pkg::mac_addr_t      exp_src;
  logic [15:0]                exp_type;
  eth_tx_pkg::length_t        exp_len;
  logic [31:0]                exp_fcs;
  logic [FIFO_DEPTH-1:0][7:0] exp_pld;
  int                         frame_errs;
  int                         apb_errs;
  int                         frames_seen;
  int                         setup_errs = 0;
  longint                     wd_ns = 0;
  logic [16:0]                lfsr;
  int                         n_pat = 0;
  eth_tx_pkg::mac_addr_t      pat_dst [MAX_FRAMES];
  eth_tx_pkg::mac_addr_t      pat_src [MAX_FRAMES];
  logic [15:0]                pat_type [MAX_FRAMES];
  int                         pat_len [MAX_FRAMES];
  logic [31:0]                pat_fcs [MAX_FRAMES];

  eth_tx_top #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_eth_tx_top (
    .clk      (clk),
    .fsm_rst  (fsm_rst),
    .apb_req  (apb_req),
    .apb_rsp  (apb_rsp),
    .phy      (phy),
    .irq_done (irq_done)
  );

  eth_tx_checker #(.FIFO_DEPTH (FIFO_DEPTH)) u_checker (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) cyc <= cyc + 1;

  initial begin
    wait (wd_ns > 0);
    #(wd_ns);
    $display("Watchdog expired after %0d ns, the DUT never finished", wd_ns);
    $display("Test FAILED");
    $finish;
  end

  // Fibonacci LFSR x^17 + x^14 + 1, one step per bit
  function automatic logic [7:0] rand_byte();
    logic [7:0] b;
    b = '0;
    for (int k = 0; k < 8; k++) begin
      lfsr = {lfsr[15:0], lfsr[16] ^ lfsr[13]};
      b    = {b[6:0], lfsr[0]};
    end
    return b;
  endfunction

  function automatic longint watchdog_cycles();
    longint c;
    c = 2 * (FIFO_DEPTH + 8) + 100;
    for (int i = 0; i < n_pat; i++) begin
      c += eth_tx_pkg::HDR_LEN + ((pat_len[i] < 46) ? 46 : pat_len[i]) + 4; // On the wire
      c += 2 * (pat_len[i] + 10); // APB accesses
    end
    return c;
  endfunction

  task automatic read_patterns();
    int          fd;
    string       line;
    logic [47:0] d;
    logic [47:0] s;
    logic [15:0] t;
    int          l;
    logic [31:0] f;
    fd = $fopen("test/eth_tx_patterns.txt", "r");
    if (fd == 0) begin
      $display("Cannot open test/eth_tx_patterns.txt");
      setup_errs++;
      return;
    end
    while (!$feof(fd) && n_pat < MAX_FRAMES) begin
      if ($fgets(line, fd) > 0 && line[0] != "#" &&
          $sscanf(line, "%h %h %h %d %h", d, s, t, l, f) == 5) begin
        pat_dst[n_pat]  = d;
        pat_src[n_pat]  = s;
        pat_type[n_pat] = t;
        pat_len[n_pat]  = l;
        pat_fcs[n_pat]  = f;
        n_pat++;
      end
    end
    $fclose(fd);
  endtask

  // Setup then access phase; the checker samples the response mid access
  task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                            input logic err, input logic [31:0] rdata);
    apb_req = '{1'b1, 1'b0, wr, addr, wdata};
    @(posedge clk);
    #10;
    apb_req.penable = 1'b1;
    chk_rsp = 1'b1;
    chk_rd  = !wr;
    exp_err = err;
    exp_rd  = rdata;
    acc_cyc = cyc;
    @(posedge clk);
    #10;
    apb_req = '0;
    chk_rsp = 1'b0;
  endtask

  task automatic send_frame(input int i, input logic busy_test);
    exp_dst  = pat_dst[i];
    exp_src  = pat_src[i];
    exp_type = pat_type[i];
    exp_len  = eth_tx_pkg::length_t'(pat_len[i]);
    exp_fcs  = pat_fcs[i];
    apb_access(1'b1, eth_tx_pkg::SRC_LO, exp_src[31:0], 1'b0, '0);
    apb_access(1'b1, eth_tx_pkg::SRC_HI, {16'd0, exp_src[47:32]}, 1'b0, '0);
    apb_access(1'b1, eth_tx_pkg::DST_LO, exp_dst[31:0], 1'b0, '0);
    apb_access(1'b1, eth_tx_pkg::DST_HI, {16'd0, exp_dst[47:32]}, 1'b0, '0);
    apb_access(1'b1, eth_tx_pkg::TYPE_LEN, {5'd0, exp_len, exp_type}, 1'b0, '0);
    for (int b = 0; b < pat_len[i]; b++) begin
      exp_pld[b] = rand_byte();
      apb_access(1'b1, eth_tx_pkg::PAYLOAD, {24'd0, exp_pld[b]}, 1'b0, '0);
    end
    apb_access(1'b1, eth_tx_pkg::CTRL, 32'd1, 1'b0, '0);
    exp_start = acc_cyc;
    exp_push  = 1'b1;
    @(posedge clk);
    #10;
    exp_push = 1'b0;
    if (busy_test) apb_access(1'b1, eth_tx_pkg::CTRL, 32'd1, 1'b1, '0); // Start while busy
    do @(negedge clk); while (!irq_done);
    @(posedge clk);
    #10;
    apb_access(1'b0, eth_tx_pkg::STATUS, '0, 1'b0, {16'(i + 1), 16'd0});
  endtask

  initial begin
    fsm_rst   = 1'b1;
    apb_req   = '0;
    chk_rsp   = 1'b0;
    chk_rd    = 1'b0;
    exp_err   = 1'b0;
    exp_rd    = '0;
    exp_push  = 1'b0;
    exp_start = 0;
    exp_dst   = '0;
    exp_src   = '0;
    exp_type  = '0;
    exp_len   = '0;
    exp_fcs   = '0;
    exp_pld   = '0;
    lfsr      = 17'd69847;
    read_patterns();
    wd_ns = watchdog_cycles() * 2 * 100;
    repeat (3) @(posedge clk);
    #10;
    fsm_rst = 1'b0;
    apb_access(1'b0, eth_tx_pkg::STATUS, '0, 1'b0, 32'd0);
    for (int i = 0; i < n_pat; i++) send_frame(i, i == 1);
    apb_access(1'b0, 8'h20, '0, 1'b1, '0); // Unmapped offset
    for (int i = 0; i < FIFO_DEPTH; i++) begin
      apb_access(1'b1, eth_tx_pkg::PAYLOAD, {24'd0, rand_byte()}, 1'b0, '0);
    end
    apb_access(1'b1, eth_tx_pkg::PAYLOAD, 32'h0000_00A5, 1'b1, '0); // FIFO already full
    apb_access(1'b0, eth_tx_pkg::STATUS, '0, 1'b0, {16'(n_pat), 8'(FIFO_DEPTH), 8'd0});
    repeat (40) @(posedge clk); // Room for a stray frame to show up
    #10;
    if (n_pat == 0 || frames_seen != n_pat) begin
      $display("%0d frames seen for %0d pattern lines", frames_seen, n_pat);
      setup_errs++;
    end
    $display("Errors: frame %0d, apb %0d, setup %0d, over %0d frames",
             frame_errs, apb_errs, setup_errs, frames_seen);
    if (frame_errs + apb_errs + setup_errs == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

//--- tb.f
verilog/eth_tx_pkg.sv
verilog/eth_crc32.sv
verilog/mac_tx.sv
verilog/eth_tx_regs.sv
verilog/eth_tx_top.sv
test/eth_tx_checker.sv
test/tb_eth_tx.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the Ethernet TX testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_eth_tx -f tb.f

./obj_dir/Vtb_eth_tx | tee sim.log

if grep -q "Test FAILED" sim.log; then
  echo "Simulation reported a failure"
  exit 1
fi

# A run cut short by an assertion prints neither message
grep -q "Test OK" sim.log

//--- test/eth_tx_patterns.txt
# dst_mac src_mac ethertype length(decimal) fcs(hex)
# Payload bytes come from the testbench LFSR, fcs 00000000 means compare with computed CRC only
0180c2000001 02aabbccdd01 8808 1 00000000
ffffffffffff 02aabbccdd02 0806 45 00000000
001122334455 02aabbccdd03 0800 46 00000000
66778899aabb 02aabbccdd04 86dd 60 00000000
